// ==== Bender.yml ====
package:
  name: accel_top

sources:
  - hdl/accel_data_pkg.sv
  - hdl/accel_regs_pkg.sv
  - hdl/accel_ctrl.sv
  - hdl/pkt_rd_dma.sv
  - hdl/fast_pattern_match.sv
  - hdl/ip_block_match.sv
  - hdl/accel_top.sv
  - target: test
    files:
      - tb/tb_accel_top.sv

// ==== flist.f ====
hdl/accel_data_pkg.sv
hdl/accel_regs_pkg.sv
hdl/accel_ctrl.sv
hdl/pkt_rd_dma.sv
hdl/fast_pattern_match.sv
hdl/ip_block_match.sv
hdl/accel_top.sv
tb/tb_accel_top.sv

// ==== hdl/accel_ctrl.sv ====
`timescale 1ns/10ps

module accel_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  // register port
  input  logic                      io_en,
  input  logic                      io_wen,
  input  accel_data_pkg::io_strb_t  io_strb,
  input  accel_data_pkg::io_addr_t  io_addr,
  input  accel_data_pkg::io_data_t  io_wr_data,
  output accel_data_pkg::io_data_t  io_rd_data,
  output logic                      io_rd_valid,
  // read engine
  output logic                      desc_valid,
  output accel_data_pkg::pkt_addr_t desc_addr,
  output accel_data_pkg::pkt_len_t  desc_len,
  output logic                      stop,
  input  logic                      busy,
  input  logic                      desc_error,
  // matcher
  output logic                      pm_init,
  output accel_data_pkg::pm_state_t preamble,
  input  logic                      match_hit,
  input  accel_data_pkg::rule_id_t  match_rule,
  input  accel_data_pkg::pm_state_t final_state,
  input  logic                      final_valid,
  // ip checker
  output logic                      ip_valid,
  output accel_data_pkg::ip_addr_t  ip_key,
  input  logic                      ip_match,
  input  logic                      ip_done
);

  import accel_data_pkg::*;
  import accel_regs_pkg::*;

  logic [REG_OFF_W-1:0] reg_off;
  logic                 status_done;
  logic                 status_match;
  logic                 done_err;
  rule_id_t             rule_q;
  pm_state_t            state_q;
  logic                 pat_ready;
  logic                 rd_stall;
  logic                 rd_ready;
  io_data_t             rd_mux;

  assign reg_off = io_addr[REG_OFF_W-1:0];

  // a result only counts once the start that clears it has gone through
  assign pat_ready = (status_done | status_match) & ~pm_init;

  always_ff @(posedge clk) begin
    desc_valid <= 1'b0;
    stop       <= 1'b0;
    pm_init    <= 1'b0;
    ip_valid   <= 1'b0;

    if (io_en && io_wen) begin
      if (io_addr[ADDR_IP_BIT]) begin
        // packet byte order is reversed against the table
        ip_key   <= {io_wr_data[7:0], io_wr_data[15:8],
                     io_wr_data[23:16], io_wr_data[31:24]};
        ip_valid <= 1'b1;
      end else if (!io_addr[ADDR_STAT_BIT]) begin
        case (reg_off)
          REG_CTRL: begin
            if (io_strb[0]) begin
              desc_valid <= io_wr_data[CTRL_START_BIT];
              pm_init    <= io_wr_data[CTRL_START_BIT];
              stop       <= io_wr_data[CTRL_STOP_BIT];
            end
          end
          REG_LEN: begin
            if (io_strb[0]) begin
              desc_len[7:0] <= io_wr_data[7:0];
            end
            if (io_strb[1]) begin
              desc_len[PKT_LEN_W-1:8] <= io_wr_data[PKT_LEN_W-1:8];
            end
          end
          REG_ADDR: begin
            if (io_strb[0]) begin
              desc_addr <= io_wr_data[PKT_ADDR_W-1:0];
            end
          end
          REG_PREAMBLE: begin
            if (io_strb[0]) begin
              preamble <= io_wr_data[7:0];
            end
          end
          default: ;
        endcase
      end
    end

    if (rst) begin
      desc_valid <= 1'b0;
      stop       <= 1'b0;
      pm_init    <= 1'b0;
      ip_valid   <= 1'b0;
    end
  end

  // sticky status bits and the captured result
  always_ff @(posedge clk) begin
    status_done  <= (status_done | final_valid | stop) & ~pm_init;
    status_match <= (status_match | match_hit) & ~pm_init;
    done_err     <= done_err | ((final_valid | stop) & busy);
    if (match_hit) begin
      rule_q <= match_rule;
    end
    if (final_valid) begin
      state_q <= final_state;
    end

    if (rst) begin
      status_done  <= 1'b0;
      status_match <= 1'b0;
      done_err     <= 1'b0;
    end
  end

  // read data select where a low rd_ready makes the read wait
  always_comb begin
    rd_mux   = '0;
    rd_ready = 1'b1;
    if (io_addr[ADDR_IP_BIT]) begin
      rd_mux[0] = ip_match;
      rd_ready  = ip_done & ~ip_valid;
    end else if (io_addr[ADDR_STAT_BIT]) begin
      case (reg_off)
        STAT_ANY:      rd_mux[0] = status_done | status_match;
        STAT_DONE:     rd_mux[0] = status_done;
        STAT_MATCH:    rd_mux[0] = status_match;
        STAT_BUSY:     rd_mux[0] = busy;
        STAT_DESC_ERR: rd_mux[0] = desc_error;
        STAT_DONE_ERR: rd_mux[0] = done_err;
        default: ;
      endcase
    end else begin
      case (reg_off)
        REG_CTRL: begin
          rd_mux[CTRL_BUSY_BIT]  = busy;
          rd_mux[CTRL_DONE_BIT]  = status_done;
          rd_mux[CTRL_MATCH_BIT] = status_match;
        end
        REG_LEN:      rd_mux = io_data_t'(desc_len);
        REG_ADDR:     rd_mux = io_data_t'(desc_addr);
        REG_RESULT: begin
          rd_mux[RESULT_MATCH_BIT] = status_match;
          rd_mux[RULE_ID_W-1:0]    = rule_q;
          rd_ready                 = pat_ready;
        end
        REG_PREAMBLE: rd_mux = io_data_t'(preamble);
        REG_STATE:    rd_mux = io_data_t'(state_q);
        default: ;
      endcase
    end
  end

  // host holds io_addr while a read is stalled, so the mux stays valid
  always_ff @(posedge clk) begin
    io_rd_valid <= 1'b0;
    if ((io_en && !io_wen) || rd_stall) begin
      io_rd_data  <= rd_mux;
      io_rd_valid <= rd_ready;
      rd_stall    <= ~rd_ready;
    end

    if (rst) begin
      io_rd_valid <= 1'b0;
      rd_stall    <= 1'b0;
    end
  end

endmodule

// ==== hdl/accel_data_pkg.sv ====
package accel_data_pkg;

  localparam int IO_DATA_W      = 32;
  localparam int IO_ADDR_W      = 12;
  localparam int PKT_WORD_BYTES = 4;
  localparam int PKT_ADDR_W     = 8;
  localparam int PKT_MEM_WORDS  = 256;
  localparam int PKT_LEN_W      = 14;
  localparam int RULE_COUNT     = 16;
  localparam int RULE_ID_W      = 4;
  localparam int RULE_PAIR_W    = 16;
  localparam int IP_COUNT       = 8;
  localparam int IP_IDX_W       = 3;
  localparam int IP_ADDR_W      = 32;

  // rule port encoding, bit 4 of the address picks the IP table
  localparam int RULE_SEL_BIT   = 4;
  localparam int RULE_VALID_BIT = 16;
  localparam int IP_VALID_BIT   = 32;

  typedef logic [IO_DATA_W-1:0]        io_data_t;
  typedef logic [IO_ADDR_W-1:0]        io_addr_t;
  typedef logic [IO_DATA_W/8-1:0]      io_strb_t;
  typedef logic [8*PKT_WORD_BYTES-1:0] pkt_word_t;
  typedef logic [PKT_ADDR_W-1:0]       pkt_addr_t;
  typedef logic [PKT_LEN_W-1:0]        pkt_len_t;
  // word count, one bit wider than len/4 so a full length rounds up safely
  typedef logic [PKT_LEN_W-2:0]        pkt_words_t;
  typedef logic [1:0]                  byte_cnt_t;
  typedef logic [7:0]                  pm_state_t;
  typedef logic [RULE_PAIR_W-1:0]      rule_pair_t;
  typedef logic [RULE_ID_W-1:0]        rule_id_t;
  typedef logic [IP_IDX_W-1:0]         ip_idx_t;
  typedef logic [IP_ADDR_W-1:0]        ip_addr_t;
  typedef logic [RULE_SEL_BIT:0]       rule_wr_addr_t;
  typedef logic [IP_VALID_BIT:0]       rule_wr_data_t;

endpackage

// ==== hdl/accel_regs_pkg.sv ====
package accel_regs_pkg;

  // address decode, bit 11 picks the IP checker and bit 10 the status group
  localparam int ADDR_IP_BIT   = 11;
  localparam int ADDR_STAT_BIT = 10;

  // register offset field inside a group
  localparam int REG_OFF_W = 6;

  // accelerator registers
  localparam logic [REG_OFF_W-1:0] REG_CTRL     = 6'h00;
  localparam logic [REG_OFF_W-1:0] REG_LEN      = 6'h04;
  localparam logic [REG_OFF_W-1:0] REG_ADDR     = 6'h08;
  localparam logic [REG_OFF_W-1:0] REG_RESULT   = 6'h0C;
  localparam logic [REG_OFF_W-1:0] REG_PREAMBLE = 6'h10;
  localparam logic [REG_OFF_W-1:0] REG_STATE    = 6'h18;

  // status group
  localparam logic [REG_OFF_W-1:0] STAT_ANY      = 6'h00;
  localparam logic [REG_OFF_W-1:0] STAT_DONE     = 6'h04;
  localparam logic [REG_OFF_W-1:0] STAT_MATCH    = 6'h08;
  localparam logic [REG_OFF_W-1:0] STAT_BUSY     = 6'h0C;
  localparam logic [REG_OFF_W-1:0] STAT_DESC_ERR = 6'h10;
  localparam logic [REG_OFF_W-1:0] STAT_DONE_ERR = 6'h14;

  // REG_CTRL write fields
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_STOP_BIT  = 4;

  // REG_CTRL read fields
  localparam int CTRL_BUSY_BIT  = 1;
  localparam int CTRL_DONE_BIT  = 8;
  localparam int CTRL_MATCH_BIT = 9;

  // REG_RESULT read field
  localparam int RESULT_MATCH_BIT = 8;

endpackage

// ==== hdl/accel_top.sv ====
`timescale 1ns/10ps

module accel_top (
  input  logic                          clk,
  input  logic                          rst,
  // register port
  input  logic                          io_en,
  input  logic                          io_wen,
  input  accel_data_pkg::io_strb_t      io_strb,
  input  accel_data_pkg::io_addr_t      io_addr,
  input  accel_data_pkg::io_data_t      io_wr_data,
  output accel_data_pkg::io_data_t      io_rd_data,
  output logic                          io_rd_valid,
  // rule port
  input  logic                          rule_wr_en,
  input  accel_data_pkg::rule_wr_addr_t rule_wr_addr,
  input  accel_data_pkg::rule_wr_data_t rule_wr_data,
  // packet memory
  output logic                          mem_rd_en,
  output accel_data_pkg::pkt_addr_t     mem_rd_addr,
  input  accel_data_pkg::pkt_word_t     mem_rd_data
);

  import accel_data_pkg::*;

  logic      desc_valid;
  pkt_addr_t desc_addr;
  pkt_len_t  desc_len;
  logic      stop;
  logic      busy;
  logic      desc_error;
  logic      pm_init;
  pm_state_t preamble;
  pkt_word_t s_data;
  logic      s_valid;
  logic      s_last;
  byte_cnt_t s_empty;
  logic      match_hit;
  rule_id_t  match_rule;
  pm_state_t final_state;
  logic      final_valid;
  logic      ip_valid;
  ip_addr_t  ip_key;
  logic      ip_match;
  logic      ip_done;

  accel_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .desc_valid(desc_valid), .desc_addr(desc_addr), .desc_len(desc_len), .stop(stop),
    .busy(busy), .desc_error(desc_error),
    .pm_init(pm_init), .preamble(preamble),
    .match_hit(match_hit), .match_rule(match_rule),
    .final_state(final_state), .final_valid(final_valid),
    .ip_valid(ip_valid), .ip_key(ip_key), .ip_match(ip_match), .ip_done(ip_done)
  );

  pkt_rd_dma u_dma (
    .clk(clk), .rst(rst),
    .desc_valid(desc_valid), .desc_addr(desc_addr), .desc_len(desc_len), .stop(stop),
    .busy(busy), .desc_error(desc_error),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data),
    .s_data(s_data), .s_valid(s_valid), .s_last(s_last), .s_empty(s_empty)
  );

  fast_pattern_match u_fpm (
    .clk(clk), .rst(rst),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .pm_init(pm_init), .preamble(preamble),
    .s_data(s_data), .s_valid(s_valid), .s_last(s_last), .s_empty(s_empty),
    .match_hit(match_hit), .match_rule(match_rule),
    .final_state(final_state), .final_valid(final_valid)
  );

  ip_block_match u_ip (
    .clk(clk), .rst(rst),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .ip_valid(ip_valid), .ip_key(ip_key), .ip_match(ip_match), .ip_done(ip_done)
  );

endmodule

// ==== hdl/fast_pattern_match.sv ====
`timescale 1ns/10ps

module fast_pattern_match (
  input  logic                          clk,
  input  logic                          rst,
  // rule port
  input  logic                          rule_wr_en,
  input  accel_data_pkg::rule_wr_addr_t rule_wr_addr,
  input  accel_data_pkg::rule_wr_data_t rule_wr_data,
  // control
  input  logic                          pm_init,
  input  accel_data_pkg::pm_state_t     preamble,
  // byte stream
  input  accel_data_pkg::pkt_word_t     s_data,
  input  logic                          s_valid,
  input  logic                          s_last,
  input  accel_data_pkg::byte_cnt_t     s_empty,
  // result
  output logic                          match_hit,
  output accel_data_pkg::rule_id_t      match_rule,
  output accel_data_pkg::pm_state_t     final_state,
  output logic                          final_valid
);

  import accel_data_pkg::*;

  logic [RULE_COUNT-1:0] rule_valid;
  rule_pair_t            rule_pair [RULE_COUNT];
  rule_pair_t            pair [PKT_WORD_BYTES];
  pm_state_t             carry;
  byte_cnt_t             last_idx;
  logic                  hit_seen;
  logic                  hit_any;
  rule_id_t              hit_id;
  logic                  rule_we;

  assign rule_we = rule_wr_en & ~rule_wr_addr[RULE_SEL_BIT];

  always_ff @(posedge clk) begin
    if (rule_we) begin
      rule_valid[rule_wr_addr[RULE_ID_W-1:0]] <= rule_wr_data[RULE_VALID_BIT];
    end
    if (rst) begin
      rule_valid <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rule_we) begin
      rule_pair[rule_wr_addr[RULE_ID_W-1:0]] <= rule_wr_data[RULE_PAIR_W-1:0];
    end
  end

  // index of the last valid byte in this word
  assign last_idx = ~s_empty;

  // pair 0 joins the byte carried over from the previous word
  always_comb begin
    pair[0] = {carry, s_data[7:0]};
    for (int i = 1; i < PKT_WORD_BYTES; i++) begin
      pair[i] = {s_data[8*(i-1) +: 8], s_data[8*i +: 8]};
    end
  end

  // walk down so the lowest matching rule wins
  always_comb begin
    hit_any = 1'b0;
    hit_id  = '0;
    for (int r = RULE_COUNT-1; r >= 0; r--) begin
      for (int i = 0; i < PKT_WORD_BYTES; i++) begin
        if (rule_valid[r] && (i <= int'(last_idx)) && (pair[i] == rule_pair[r])) begin
          hit_any = 1'b1;
          hit_id  = rule_id_t'(r);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    match_hit   <= 1'b0;
    final_valid <= 1'b0;
    if (pm_init) begin
      carry    <= preamble;
      hit_seen <= 1'b0;
    end else if (s_valid) begin
      carry       <= s_data[8*last_idx +: 8];
      final_valid <= s_last;
      // only the first hit of a packet is reported
      if (hit_any && !hit_seen) begin
        match_hit  <= 1'b1;
        match_rule <= hit_id;
        hit_seen   <= 1'b1;
      end
    end

    if (rst) begin
      match_hit   <= 1'b0;
      final_valid <= 1'b0;
      hit_seen    <= 1'b0;
    end
  end

  // after the last word the carried byte is the final state
  assign final_state = carry;

endmodule

// ==== hdl/ip_block_match.sv ====
`timescale 1ns/10ps

module ip_block_match (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rule_wr_en,
  input  accel_data_pkg::rule_wr_addr_t rule_wr_addr,
  input  accel_data_pkg::rule_wr_data_t rule_wr_data,
  input  logic                          ip_valid,
  input  accel_data_pkg::ip_addr_t      ip_key,
  output logic                          ip_match,
  output logic                          ip_done
);

  import accel_data_pkg::*;

  logic [IP_COUNT-1:0] tbl_valid;
  ip_addr_t            tbl_addr [IP_COUNT];
  ip_addr_t            key_q;
  ip_idx_t             idx;
  ip_idx_t             cur_idx;
  ip_addr_t            cur_key;
  logic                cur_hit;
  logic                searching;
  logic                tbl_we;

  assign tbl_we = rule_wr_en & rule_wr_addr[RULE_SEL_BIT];

  always_ff @(posedge clk) begin
    if (tbl_we) begin
      tbl_valid[rule_wr_addr[IP_IDX_W-1:0]] <= rule_wr_data[IP_VALID_BIT];
    end
    if (rst) begin
      tbl_valid <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (tbl_we) begin
      tbl_addr[rule_wr_addr[IP_IDX_W-1:0]] <= rule_wr_data[IP_ADDR_W-1:0];
    end
  end

  // entry 0 is compared in the ip_valid cycle itself
  assign cur_idx = ip_valid ? '0 : idx;
  assign cur_key = ip_valid ? ip_key : key_q;
  assign cur_hit = tbl_valid[cur_idx] && (tbl_addr[cur_idx] == cur_key);

  always_ff @(posedge clk) begin
    if (ip_valid) begin
      key_q     <= ip_key;
      idx       <= ip_idx_t'(1);
      searching <= 1'b1;
      ip_match  <= cur_hit;
      ip_done   <= 1'b0;
    end else if (searching) begin
      idx      <= idx + 1'b1;
      ip_match <= ip_match | cur_hit;
      if (idx == ip_idx_t'(IP_COUNT-1)) begin
        searching <= 1'b0;
        ip_done   <= 1'b1;
      end
    end

    if (rst) begin
      searching <= 1'b0;
      ip_match  <= 1'b0;
      ip_done   <= 1'b0;
    end
  end

endmodule

// ==== hdl/pkt_rd_dma.sv ====
`timescale 1ns/10ps

module pkt_rd_dma (
  input  logic                      clk,
  input  logic                      rst,
  // descriptor
  input  logic                      desc_valid,
  input  accel_data_pkg::pkt_addr_t desc_addr,
  input  accel_data_pkg::pkt_len_t  desc_len,
  input  logic                      stop,
  output logic                      busy,
  output logic                      desc_error,
  // packet memory
  output logic                      mem_rd_en,
  output accel_data_pkg::pkt_addr_t mem_rd_addr,
  input  accel_data_pkg::pkt_word_t mem_rd_data,
  // byte stream
  output accel_data_pkg::pkt_word_t s_data,
  output logic                      s_valid,
  output logic                      s_last,
  output accel_data_pkg::byte_cnt_t s_empty
);

  import accel_data_pkg::*;

  pkt_words_t num_words;
  pkt_words_t end_word;
  pkt_words_t words_left;
  logic       desc_bad;
  logic       rd_last;
  byte_cnt_t  empty_q;
  logic       valid_q;
  logic       last_q;

  // length rounded up to whole words
  assign num_words = pkt_words_t'(desc_len[PKT_LEN_W-1:2])
                   + pkt_words_t'(desc_len[1:0] != 2'b00);
  assign end_word  = pkt_words_t'(desc_addr) + num_words;
  assign desc_bad  = (desc_len == '0) || (end_word > pkt_words_t'(PKT_MEM_WORDS));

  assign rd_last   = (words_left == pkt_words_t'(1));
  assign mem_rd_en = busy & ~stop;

  always_ff @(posedge clk) begin
    if (mem_rd_en) begin
      mem_rd_addr <= mem_rd_addr + 1'b1;
      words_left  <= words_left - 1'b1;
      if (rd_last) begin
        busy <= 1'b0;
      end
    end

    // a start while busy is rejected like a bad descriptor
    if (desc_valid) begin
      if (busy || desc_bad) begin
        desc_error <= 1'b1;
      end else begin
        desc_error  <= 1'b0;
        busy        <= 1'b1;
        mem_rd_addr <= desc_addr;
        words_left  <= num_words;
        empty_q     <= 2'd0 - desc_len[1:0];
      end
    end

    if (stop) begin
      busy <= 1'b0;
    end

    // memory answers one cycle after the read
    valid_q <= mem_rd_en;
    last_q  <= mem_rd_en & rd_last;

    if (rst) begin
      busy       <= 1'b0;
      desc_error <= 1'b0;
      valid_q    <= 1'b0;
      last_q     <= 1'b0;
    end
  end

  // the word still in flight when stop arrives is dropped
  assign s_data  = mem_rd_data;
  assign s_valid = valid_q & ~stop;
  assign s_last  = last_q;
  assign s_empty = last_q ? empty_q : 2'd0;

endmodule

// ==== tb/tb_accel_top.sv ====
`timescale 1ns/10ps

module tb_accel_top;

  import accel_data_pkg::*;
  import accel_regs_pkg::*;

  localparam int       CLK_PERIOD   = 8;
  localparam int       READ_LIMIT   = 64;
  localparam int       DONE_POLLS   = 40;
  localparam int       LONG_PKT_LEN = 1000;
  localparam int       NUM_TESTS    = 6;
  // rough upper bound for one directed test with stalled reads and polling
  localparam int       TEST_CYCLES  = 2 * READ_LIMIT + 4 * DONE_POLLS;
  localparam int       RUN_CYCLES   = 4 + NUM_TESTS * TEST_CYCLES + LONG_PKT_LEN / 4;
  localparam int       WATCHDOG_NS  = 2 * RUN_CYCLES * CLK_PERIOD;
  localparam io_addr_t IP_PORT      = io_addr_t'(1) << ADDR_IP_BIT;
  localparam io_data_t MATCH_MASK   = io_data_t'(1) << RESULT_MATCH_BIT;

  logic          clk;
  logic          rst;
  logic          io_en;
  logic          io_wen;
  io_strb_t      io_strb;
  io_addr_t      io_addr;
  io_data_t      io_wr_data;
  io_data_t      io_rd_data;
  logic          io_rd_valid;
  logic          rule_wr_en;
  rule_wr_addr_t rule_wr_addr;
  rule_wr_data_t rule_wr_data;
  logic          mem_rd_en;
  pkt_addr_t     mem_rd_addr;
  pkt_word_t     mem_rd_data;

  pkt_word_t  pkt_mem [PKT_MEM_WORDS];
  logic       rule_v [RULE_COUNT];
  rule_pair_t rule_p [RULE_COUNT];
  logic       ip_v [IP_COUNT];
  ip_addr_t   ip_tab [IP_COUNT];
  logic [31:0] lfsr_q;
  int          mem_reads;
  int          checks;
  int          errors;
  int          timeouts;

  accel_top UUT (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // synchronous packet memory with one cycle of read latency
  always @(posedge clk) begin
    if (mem_rd_en) begin
      mem_rd_data <= pkt_mem[mem_rd_addr];
      mem_reads   <= mem_reads + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  // galois lfsr stepped once per random bit
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      b = {b[6:0], lfsr_q[0]};
    end
    return b;
  endfunction

  function automatic io_addr_t stat_addr(input logic [REG_OFF_W-1:0] off);
    return io_addr_t'(off) | (io_addr_t'(1) << ADDR_STAT_BIT);
  endfunction

  function automatic ip_addr_t byte_swap(input ip_addr_t a);
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  function automatic logic ip_ref(input ip_addr_t a);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < IP_COUNT; i++) begin
      if (ip_v[i] && ip_tab[i] == a) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // the first word with a matching pair decides and its lowest rule id wins
  task automatic pattern_ref(input pkt_addr_t addr, input int len, input pm_state_t pre,
                             output logic hit, output rule_id_t rule, output pm_state_t last);
    pkt_word_t word;
    pm_state_t prev;
    pm_state_t first;
    int        nbytes;
    logic      found;
    rule_id_t  best;
    prev = pre;
    hit  = 1'b0;
    rule = '0;
    for (int w = 0; w < (len + 3) / 4; w++) begin
      word   = pkt_mem[pkt_addr_t'(addr + w)];
      nbytes = (len - 4 * w < 4) ? len - 4 * w : 4;
      found  = 1'b0;
      best   = '0;
      for (int r = 0; r < RULE_COUNT; r++) begin
        for (int i = 0; i < nbytes; i++) begin
          first = (i == 0) ? prev : word[8*(i-1) +: 8];
          if (!found && rule_v[r] && ({first, word[8*i +: 8]} == rule_p[r])) begin
            found = 1'b1;
            best  = rule_id_t'(r);
          end
        end
      end
      if (found && !hit) begin
        hit  = 1'b1;
        rule = best;
      end
      prev = word[8*(nbytes-1) +: 8];
    end
    last = prev;
  endtask

  task automatic check_data(input io_data_t got, input io_data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s, got 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic check_rule(input rule_id_t got, input rule_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s, got rule %0d, expected rule %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_state(input pm_state_t got, input pm_state_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s, got state 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input io_addr_t addr, input io_data_t data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = '1;
    io_addr    = addr;
    io_wr_data = data;
    idle(1);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  // the address stays on the bus until io_rd_valid since the read may stall
  task automatic read_reg(input io_addr_t addr, output io_data_t data);
    int n;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    idle(1);
    io_en = 1'b0;
    n = 0;
    while (!io_rd_valid && n < READ_LIMIT) begin
      idle(1);
      n++;
    end
    data = 'x;
    if (io_rd_valid) begin
      data = io_rd_data;
    end else begin
      timeouts++;
      $display("read of address 0x%h got no response within %0d cycles", addr, READ_LIMIT);
    end
  endtask

  task automatic write_rule(input int idx, input rule_pair_t pair);
    rule_wr_en   = 1'b1;
    rule_wr_addr = rule_wr_addr_t'(idx);
    rule_wr_data = rule_wr_data_t'({1'b1, pair});
    rule_v[idx]  = 1'b1;
    rule_p[idx]  = pair;
    idle(1);
    rule_wr_en = 1'b0;
  endtask

  task automatic write_ip_entry(input int idx, input ip_addr_t a, input logic valid);
    rule_wr_en   = 1'b1;
    rule_wr_addr = rule_wr_addr_t'(idx) | (rule_wr_addr_t'(1) << RULE_SEL_BIT);
    rule_wr_data = {valid, a};
    ip_v[idx]    = valid;
    ip_tab[idx]  = a;
    idle(1);
    rule_wr_en = 1'b0;
  endtask

  task automatic put_byte(input pkt_addr_t addr, input int idx, input logic [7:0] b);
    pkt_word_t w;
    w = pkt_mem[pkt_addr_t'(addr + idx / 4)];
    w[8*(idx%4) +: 8] = b;
    pkt_mem[pkt_addr_t'(addr + idx / 4)] = w;
  endtask

  // two spare cycles let the start clear status and reach the read engine
  task automatic start_packet(input pkt_addr_t addr, input int len, input pm_state_t pre);
    write_reg(io_addr_t'(REG_ADDR), io_data_t'(addr));
    write_reg(io_addr_t'(REG_LEN), io_data_t'(len));
    write_reg(io_addr_t'(REG_PREAMBLE), io_data_t'(pre));
    write_reg(io_addr_t'(REG_CTRL), io_data_t'(1) << CTRL_START_BIT);
    idle(2);
  endtask

  task automatic wait_done(input string what);
    io_data_t rd;
    int       n;
    n  = 0;
    rd = '0;
    while (rd[0] !== 1'b1 && n < DONE_POLLS) begin
      read_reg(stat_addr(STAT_DONE), rd);
      n++;
    end
    if (rd[0] !== 1'b1) begin
      timeouts++;
      $display("%s: done was never set after %0d status polls", what, DONE_POLLS);
    end
  endtask

  task automatic packet_result(input pkt_addr_t addr, input int len, input pm_state_t pre,
                               input string what);
    io_data_t  rd;
    logic      exp_hit;
    rule_id_t  exp_rule;
    pm_state_t exp_state;
    pattern_ref(addr, len, pre, exp_hit, exp_rule, exp_state);
    start_packet(addr, len, pre);
    read_reg(io_addr_t'(REG_RESULT), rd);
    check_data(rd & MATCH_MASK, exp_hit ? MATCH_MASK : '0, $sformatf("%s match flag", what));
    if (exp_hit) begin
      check_rule(rd[RULE_ID_W-1:0], exp_rule, $sformatf("%s rule id", what));
    end
    wait_done(what);
    read_reg(io_addr_t'(REG_STATE), rd);
    check_state(rd[7:0], exp_state, $sformatf("%s final state", what));
  endtask

  task automatic register_path();
    io_data_t rd;
    read_reg(stat_addr(STAT_BUSY), rd);
    check_data(rd, '0, "busy after reset");
    read_reg(stat_addr(STAT_DONE), rd);
    check_data(rd, '0, "done after reset");
    read_reg(stat_addr(STAT_MATCH), rd);
    check_data(rd, '0, "match after reset");
    read_reg(stat_addr(STAT_DONE_ERR), rd);
    check_data(rd, '0, "done error after reset");
    write_reg(io_addr_t'(REG_LEN), 32'h0000_1234);
    write_reg(io_addr_t'(REG_ADDR), 32'h0000_005a);
    write_reg(io_addr_t'(REG_PREAMBLE), 32'h0000_00c3);
    read_reg(io_addr_t'(REG_LEN), rd);
    check_data(rd, 32'h0000_1234, "length read back");
    read_reg(io_addr_t'(REG_ADDR), rd);
    check_data(rd, 32'h0000_005a, "address read back");
    read_reg(io_addr_t'(REG_PREAMBLE), rd);
    check_data(rd, 32'h0000_00c3, "preamble read back");
  endtask

  task automatic pattern_hit();
    write_rule(3, 16'h7e42);
    write_rule(5, 16'habcd);
    write_rule(9, 16'habcd);
    // pair split over the word 17 / word 18 boundary
    put_byte(8'd16, 7, 8'hab);
    put_byte(8'd16, 8, 8'hcd);
    packet_result(8'd16, 22, 8'h00, "boundary pair");
    // preamble pair and a higher rule in the same word
    put_byte(8'd40, 0, 8'h42);
    put_byte(8'd40, 2, 8'hab);
    put_byte(8'd40, 3, 8'hcd);
    packet_result(8'd40, 13, 8'h7e, "preamble pair");
  endtask

  task automatic pattern_miss();
    io_data_t rd;
    packet_result(8'd100, 30, 8'h5a, "no hit packet");
    read_reg(stat_addr(STAT_DONE), rd);
    check_data(rd, 32'h1, "done after no hit packet");
    read_reg(stat_addr(STAT_ANY), rd);
    check_data(rd, 32'h1, "any after no hit packet");
  endtask

  task automatic descriptor_error();
    io_data_t rd;
    int       reads0;
    reads0 = mem_reads;
    start_packet(8'd0, 0, 8'h00);
    read_reg(stat_addr(STAT_DESC_ERR), rd);
    check_data(rd, 32'h1, "error on zero length");
    start_packet(8'd250, 28, 8'h00);
    read_reg(stat_addr(STAT_DESC_ERR), rd);
    check_data(rd, 32'h1, "error on packet past memory end");
    check_data(io_data_t'(mem_reads - reads0), '0, "memory reads for rejected packets");
    start_packet(8'd0, 8, 8'h00);
    wait_done("good packet after error");
    read_reg(stat_addr(STAT_DESC_ERR), rd);
    check_data(rd, '0, "error after good start");
  endtask

  task automatic stop_packet();
    io_data_t rd;
    start_packet(8'd0, LONG_PKT_LEN, 8'h00);
    idle(8);
    read_reg(stat_addr(STAT_BUSY), rd);
    check_data(rd, 32'h1, "busy during long packet");
    write_reg(io_addr_t'(REG_CTRL), io_data_t'(1) << CTRL_STOP_BIT);
    idle(2);
    read_reg(stat_addr(STAT_DONE), rd);
    check_data(rd, 32'h1, "done after stop");
    read_reg(stat_addr(STAT_BUSY), rd);
    check_data(rd, '0, "busy after stop");
    read_reg(stat_addr(STAT_DONE_ERR), rd);
    check_data(rd, 32'h1, "done error after stop while busy");
  endtask

  task automatic ip_lookup();
    io_data_t rd;
    ip_addr_t keys [5];
    write_ip_entry(0, 32'hc0a8_0001, 1'b1);
    write_ip_entry(2, 32'hdead_beef, 1'b0);
    write_ip_entry(5, 32'h0a00_0005, 1'b1);
    write_ip_entry(7, 32'h0808_0808, 1'b1);
    keys[0] = 32'h0a00_0005;
    keys[1] = 32'h0808_0808;
    keys[2] = 32'hdead_beef;
    keys[3] = 32'hc0a8_0001;
    keys[4] = 32'h1234_5678;
    for (int k = 0; k < 5; k++) begin
      // the checker reverses the written bytes again
      write_reg(IP_PORT, byte_swap(keys[k]));
      read_reg(IP_PORT, rd);
      check_data(rd, io_data_t'(ip_ref(keys[k])), $sformatf("ip lookup %h", keys[k]));
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    rule_wr_en   = 1'b0;
    rule_wr_addr = '0;
    rule_wr_data = '0;
    mem_rd_data  = '0;
    mem_reads    = 0;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    lfsr_q       = 32'hc38b_b81e;
    for (int i = 0; i < RULE_COUNT; i++) begin
      rule_v[i] = 1'b0;
      rule_p[i] = '0;
    end
    for (int i = 0; i < IP_COUNT; i++) begin
      ip_v[i]   = 1'b0;
      ip_tab[i] = '0;
    end
    for (int w = 0; w < PKT_MEM_WORDS; w++) begin
      for (int b = 0; b < PKT_WORD_BYTES; b++) begin
        pkt_mem[w][8*b +: 8] = rand_byte();
      end
    end

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(1);

    register_path();
    pattern_hit();
    pattern_miss();
    descriptor_error();
    stop_packet();
    ip_lookup();

    $display("checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
